// ==== hw/calendarPkg.sv ====
package calendarPkg;

	// one decimal digit, 0 to 9
	typedef logic [3:0] bcdDigit;

	// tens and units of a two digit field
	typedef struct packed {
		bcdDigit hi;
		bcdDigit lo;
	} bcdPair;

	// hour in the top byte, jiffy in the bottom byte
	typedef struct packed {
		bcdPair hour;
		bcdPair minute;
		bcdPair second;
		bcdPair jiffy;
	} timeWord;

	// century and year in the top half, then month and day
	typedef struct packed {
		bcdPair yearHi;
		bcdPair yearLo;
		bcdPair month;
		bcdPair day;
	} dateWord;

	// jiffy rate select, the spare code runs at 100 Hz
	typedef enum logic [1:0] {
		RATE_100 = 2'd0,
		RATE_60  = 2'd1,
		RATE_50  = 2'd2,
		RATE_ALT = 2'd3
	} tickRate;

	// 13:06:00.00 on 2012-06-10
	localparam timeWord RESET_TIME = 32'h1306_0000;
	localparam dateWord RESET_DATE = 32'h2012_0610;

	// next value of a two digit field
	// wraps to 00 once the field reaches top
	function automatic bcdPair bcdStep(input bcdPair value, input bcdPair top);
		bcdPair result;
		result = value;
		if (value >= top) begin
			result = '0;
		end else if (value.lo >= 4'd9) begin
			result.lo = 4'd0;
			result.hi = value.hi + 4'd1;
		end else begin
			result.lo = value.lo + 4'd1;
		end
		return result;
	endfunction

endpackage

// ==== hw/rtcRegPkg.sv ====
package rtcRegPkg;

	// register number from address bits 4..2
	typedef enum logic [2:0] {
		REG_TIME       = 3'd0,
		REG_DATE       = 3'd1,
		REG_ALARM_TIME = 3'd2,
		REG_ALARM_DATE = 3'd3,
		REG_CONTROL    = 3'd4,
		REG_SNAPSHOT   = 3'd5
	} regIndex;

	localparam int IDX_LSB = 2;
	localparam int IDX_MSB = 4;

	// one bit per alarm byte
	// bits 3..0 cover the time bytes, bits 7..4 the date bytes
	typedef logic [7:0] careMask;

	// ==================================================
	// byte lanes
	// ==================================================
	// control register
	localparam int LANE_CARE = 0;
	localparam int LANE_MODE = 1;
	// snapshot register
	localparam int LANE_SNAP       = 0;
	localparam int LANE_SNAP_ALARM = 1;

	// ==================================================
	// control word bits
	// ==================================================
	localparam int CTL_CARE_LSB = 0;
	localparam int CTL_CARE_MSB = 7;
	localparam int CTL_TOD_EN   = 8;
	localparam int CTL_RATE_LSB = 9;
	localparam int CTL_RATE_MSB = 10;

	// snapshot command bits
	localparam int SNAP_CAPTURE    = 0;
	localparam int SNAP_LOAD       = 1;
	localparam int SNAP_ALARM_LOAD = 8;

endpackage

// ==== hw/todSync.sv ====
`timescale 1ns/1ps

module todSync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic clk_i,
	input  logic rst_i,
	input  logic tod_i,
	output logic todEdge_o
);

	// metastability chain, stage 0 samples the pin
	logic [SYNC_STAGES-1:0] syncChain;
	// last synchronized level, for the edge detect
	logic todLevelQ;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			syncChain <= '0;
			todLevelQ <= 1'b0;
			todEdge_o <= 1'b0;
		end else begin
			syncChain[0] <= tod_i;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				syncChain[i] <= syncChain[i-1];
			end
			todLevelQ <= syncChain[SYNC_STAGES-1];
			// registered rising edge, one clock wide
			todEdge_o <= syncChain[SYNC_STAGES-1] & ~todLevelQ;
		end
	end

endmodule

// ==== hw/timeCounter.sv ====
`timescale 1ns/1ps

module timeCounter (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                todEdge_i,
	input  logic                todEnable_i,
	input  calendarPkg::tickRate rate_i,
	input  logic                loadTime_i,
	input  calendarPkg::timeWord loadValue_i,
	output calendarPkg::timeWord time_o,
	output logic                dayTick_o
);

	import calendarPkg::*;

	// last jiffy value for the selected rate
	bcdPair jiffyTop;
	// field at its top, so the next tick carries
	logic jiffyEnd;
	logic secondEnd;
	logic minuteEnd;
	logic hourEnd;
	logic advance;
	timeWord timeNext;

	always_comb begin
		case (rate_i)
			RATE_60:  jiffyTop = 8'h59;
			RATE_50:  jiffyTop = 8'h49;
			RATE_100,
			RATE_ALT: jiffyTop = 8'h99;
			default:  jiffyTop = 8'h99;
		endcase
	end

	assign jiffyEnd  = time_o.jiffy >= jiffyTop;
	assign secondEnd = time_o.second >= 8'h59;
	assign minuteEnd = time_o.minute >= 8'h59;
	assign hourEnd   = time_o.hour >= 8'h23;

	assign advance = todEdge_i & todEnable_i;

	// ==================================================
	// carry chain
	// ==================================================
	always_comb begin
		timeNext = time_o;
		timeNext.jiffy = bcdStep(time_o.jiffy, jiffyTop);
		if (jiffyEnd) begin
			timeNext.second = bcdStep(time_o.second, 8'h59);
		end
		if (jiffyEnd && secondEnd) begin
			timeNext.minute = bcdStep(time_o.minute, 8'h59);
		end
		// hour wraps 23 to 00, so the whole word lands on zero
		if (jiffyEnd && secondEnd && minuteEnd) begin
			timeNext.hour = bcdStep(time_o.hour, 8'h23);
		end
	end

	// last tick of the day, date counter moves on the same edge
	assign dayTick_o = advance & jiffyEnd & secondEnd & minuteEnd & hourEnd;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			time_o <= RESET_TIME;
		end else if (loadTime_i) begin
			// snapshot load beats the tod tick
			time_o <= loadValue_i;
		end else if (advance) begin
			time_o <= timeNext;
		end
	end

endmodule

// ==== hw/dateCounter.sv ====
`timescale 1ns/1ps

module dateCounter (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                dayTick_i,
	input  logic                loadDate_i,
	input  calendarPkg::dateWord loadValue_i,
	output calendarPkg::dateWord date_o
);

	import calendarPkg::*;

	logic leapYear;
	// last day of the current month
	bcdPair lastDay;
	logic dayEnd;
	logic monthEnd;
	logic yearLoEnd;
	dateWord dateNext;

	// two digit BCD value divisible by 4
	// 10*t + u is 2*t + u modulo 4
	function automatic logic divBy4(input bcdPair value);
		logic [1:0] residue;
		residue = {value.hi[0], 1'b0} + value.lo[1:0];
		return residue == 2'd0;
	endfunction

	// ==================================================
	// leap year and month length
	// ==================================================
	// century years count only when the century divides by 4
	assign leapYear = (date_o.yearLo == 8'h00) ? divBy4(date_o.yearHi)
		: divBy4(date_o.yearLo);

	always_comb begin
		case (date_o.month)
			8'h02:   lastDay = leapYear ? 8'h29 : 8'h28;
			8'h04,
			8'h06,
			8'h09,
			8'h11:   lastDay = 8'h30;
			default: lastDay = 8'h31;
		endcase
	end

	assign dayEnd    = date_o.day >= lastDay;
	assign monthEnd  = date_o.month >= 8'h12;
	assign yearLoEnd = date_o.yearLo >= 8'h99;

	always_comb begin
		dateNext = date_o;
		// days and months restart at 01
		dateNext.day = dayEnd ? 8'h01 : bcdStep(date_o.day, lastDay);
		if (dayEnd) begin
			dateNext.month = monthEnd ? 8'h01 : bcdStep(date_o.month, 8'h12);
		end
		if (dayEnd && monthEnd) begin
			dateNext.yearLo = bcdStep(date_o.yearLo, 8'h99);
		end
		// 9999 rolls to 0000
		if (dayEnd && monthEnd && yearLoEnd) begin
			dateNext.yearHi = bcdStep(date_o.yearHi, 8'h99);
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			date_o <= RESET_DATE;
		end else if (loadDate_i) begin
			date_o <= loadValue_i;
		end else if (dayTick_i) begin
			date_o <= dateNext;
		end
	end

endmodule

// ==== hw/alarmMatch.sv ====
`timescale 1ns/1ps

module alarmMatch (
	input  logic                clk_i,
	input  logic                rst_i,
	input  calendarPkg::timeWord liveTime_i,
	input  calendarPkg::dateWord liveDate_i,
	input  calendarPkg::timeWord alarmTime_i,
	input  calendarPkg::dateWord alarmDate_i,
	input  rtcRegPkg::careMask   careMask_i,
	input  logic                alarmAck_i,
	output logic                alarmIrq_o
);

	// date in the upper four bytes, time in the lower four
	logic [63:0] liveBits;
	logic [63:0] alarmBits;
	logic [7:0]  byteHit;
	logic        matchNow;
	logic        matchQ;

	assign liveBits  = {liveDate_i, liveTime_i};
	assign alarmBits = {alarmDate_i, alarmTime_i};

	// a byte without its care bit always matches
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			byteHit[i] = ~careMask_i[i] | (liveBits[8*i +: 8] == alarmBits[8*i +: 8]);
		end
	end

	assign matchNow = &byteHit;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			matchQ     <= 1'b0;
			alarmIrq_o <= 1'b0;
		end else begin
			matchQ <= matchNow;
			// set on the first cycle of a match, a new edge beats the ack
			if (matchNow & ~matchQ) begin
				alarmIrq_o <= 1'b1;
			end else if (alarmAck_i) begin
				alarmIrq_o <= 1'b0;
			end
		end
	end

endmodule

// ==== hw/rtcRegs.sv ====
`timescale 1ns/1ps

module rtcRegs #(
	parameter calendarPkg::tickRate RESET_RATE = calendarPkg::RATE_100
) (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 csIo_i,
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  logic [3:0]           sel_i,
	input  logic [31:0]          adr_i,
	input  logic [31:0]          dat_i,
	input  calendarPkg::timeWord liveTime_i,
	input  calendarPkg::dateWord liveDate_i,
	output logic                 ack_o,
	output logic [31:0]          dat_o,
	output logic                 loadTime_o,
	output logic                 loadDate_o,
	output calendarPkg::timeWord shadowTime_o,
	output calendarPkg::dateWord shadowDate_o,
	output calendarPkg::timeWord alarmTime_o,
	output calendarPkg::dateWord alarmDate_o,
	output rtcRegPkg::careMask   careMask_o,
	output logic                 todEnable_o,
	output calendarPkg::tickRate rate_o,
	output logic                 alarmAck_o
);

	import calendarPkg::*;
	import rtcRegPkg::*;

	logic        access;
	// bus inputs, one clock late
	logic        accessQ;
	logic        weQ;
	logic [3:0]  selQ;
	logic [31:0] datQ;
	regIndex     idxQ;
	logic        readQ;
	logic        writeQ;
	// snapshot actions
	logic        snapWrite;
	logic        captureNow;
	logic        loadNow;
	logic        alarmLoad;
	// alarm as written, before the alarm load
	timeWord     alarmTimeShadow;
	dateWord     alarmDateShadow;
	logic [31:0] controlWord;

	// replace only the bytes with their select set
	function automatic logic [31:0] mergeLanes(input logic [31:0] oldWord,
		input logic [31:0] newWord, input logic [3:0] lanes);
		logic [31:0] result;
		result = oldWord;
		for (int i = 0; i < 4; i++) begin
			if (lanes[i]) begin
				result[8*i +: 8] = newWord[8*i +: 8];
			end
		end
		return result;
	endfunction

	// ==================================================
	// bus select and ack
	// ==================================================
	assign access = csIo_i & cyc_i & stb_i;
	// writes ack at once, reads one clock after the select
	assign ack_o = access & (we_i | readQ);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			accessQ <= 1'b0;
			weQ     <= 1'b0;
		end else begin
			accessQ <= access;
			weQ     <= we_i;
		end
	end

	always_ff @(posedge clk_i) begin
		selQ <= sel_i;
		datQ <= dat_i;
		idxQ <= regIndex'(adr_i[IDX_MSB:IDX_LSB]);
	end

	assign readQ  = accessQ & ~weQ;
	assign writeQ = accessQ & weQ;

	// register 5 commands act in the cycle after the ack
	assign snapWrite  = writeQ & (idxQ == REG_SNAPSHOT);
	assign captureNow = snapWrite & selQ[LANE_SNAP] & datQ[SNAP_CAPTURE];
	assign loadNow    = snapWrite & selQ[LANE_SNAP] & datQ[SNAP_LOAD];
	assign alarmLoad  = snapWrite & selQ[LANE_SNAP_ALARM] & datQ[SNAP_ALARM_LOAD];

	assign loadTime_o = loadNow;
	assign loadDate_o = loadNow;

	// reading either alarm word acknowledges the interrupt
	assign alarmAck_o = readQ & ((idxQ == REG_ALARM_TIME) || (idxQ == REG_ALARM_DATE));

	// ==================================================
	// shadow and alarm shadow words
	// ==================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			shadowTime_o    <= RESET_TIME;
			shadowDate_o    <= RESET_DATE;
			alarmTimeShadow <= '0;
			alarmDateShadow <= '0;
		end else begin
			// tear free copy of the live counters
			if (captureNow) begin
				shadowTime_o <= liveTime_i;
				shadowDate_o <= liveDate_i;
			end
			if (writeQ) begin
				case (idxQ)
					REG_TIME:       shadowTime_o <= timeWord'(mergeLanes(shadowTime_o, datQ, selQ));
					REG_DATE:       shadowDate_o <= dateWord'(mergeLanes(shadowDate_o, datQ, selQ));
					REG_ALARM_TIME: alarmTimeShadow <=
						timeWord'(mergeLanes(alarmTimeShadow, datQ, selQ));
					REG_ALARM_DATE: alarmDateShadow <=
						dateWord'(mergeLanes(alarmDateShadow, datQ, selQ));
					default:        ;
				endcase
			end
		end
	end

	// control and the active alarm
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			careMask_o  <= 8'hFF;
			todEnable_o <= 1'b1;
			rate_o      <= RESET_RATE;
			alarmTime_o <= '0;
			alarmDate_o <= '0;
		end else begin
			if (writeQ && (idxQ == REG_CONTROL)) begin
				if (selQ[LANE_CARE]) begin
					careMask_o <= datQ[CTL_CARE_MSB:CTL_CARE_LSB];
				end
				if (selQ[LANE_MODE]) begin
					todEnable_o <= datQ[CTL_TOD_EN];
					rate_o      <= tickRate'(datQ[CTL_RATE_MSB:CTL_RATE_LSB]);
				end
			end
			if (alarmLoad) begin
				alarmTime_o <= alarmTimeShadow;
				alarmDate_o <= alarmDateShadow;
			end
		end
	end

	// ==================================================
	// read mux
	// ==================================================
	always_comb begin
		controlWord = '0;
		controlWord[CTL_CARE_MSB:CTL_CARE_LSB] = careMask_o;
		controlWord[CTL_TOD_EN] = todEnable_o;
		controlWord[CTL_RATE_MSB:CTL_RATE_LSB] = rate_o;
	end

	// zero outside a read, so dat_o idles low
	always_comb begin
		dat_o = '0;
		if (readQ) begin
			case (idxQ)
				REG_TIME:       dat_o = shadowTime_o;
				REG_DATE:       dat_o = shadowDate_o;
				REG_ALARM_TIME: dat_o = alarmTimeShadow;
				REG_ALARM_DATE: dat_o = alarmDateShadow;
				REG_CONTROL:    dat_o = controlWord;
				// snapshot is a command, nothing to read back
				REG_SNAPSHOT:   dat_o = '0;
				default:        dat_o = '0;
			endcase
		end
	end

endmodule

// ==== hw/rtcTop.sv ====
`timescale 1ns/1ps

module rtcTop #(
	parameter int                   SYNC_STAGES = 2,
	parameter calendarPkg::tickRate RESET_RATE  = calendarPkg::RATE_100
) (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        csIo_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  sel_i,
	input  logic [31:0] adr_i,
	input  logic [31:0] dat_i,
	input  logic        tod_i,
	output logic        ack_o,
	output logic [31:0] dat_o,
	output logic        alarmIrq_o
);

	import calendarPkg::*;
	import rtcRegPkg::*;

	// live counters
	timeWord liveTime;
	dateWord liveDate;
	// register block to the counters
	timeWord shadowTime;
	dateWord shadowDate;
	logic    loadTime;
	logic    loadDate;
	logic    todEnable;
	tickRate rate;
	// register block to the alarm
	timeWord alarmTime;
	dateWord alarmDate;
	careMask alarmCare;
	logic    alarmAck;
	// tod path
	logic    todEdge;
	logic    dayTick;

	// ==================================================
	// bus and registers
	// ==================================================
	rtcRegs #(
		.RESET_RATE(RESET_RATE)
	) regs (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.csIo_i      (csIo_i),
		.cyc_i       (cyc_i),
		.stb_i       (stb_i),
		.we_i        (we_i),
		.sel_i       (sel_i),
		.adr_i       (adr_i),
		.dat_i       (dat_i),
		.liveTime_i  (liveTime),
		.liveDate_i  (liveDate),
		.ack_o       (ack_o),
		.dat_o       (dat_o),
		.loadTime_o  (loadTime),
		.loadDate_o  (loadDate),
		.shadowTime_o(shadowTime),
		.shadowDate_o(shadowDate),
		.alarmTime_o (alarmTime),
		.alarmDate_o (alarmDate),
		.careMask_o  (alarmCare),
		.todEnable_o (todEnable),
		.rate_o      (rate),
		.alarmAck_o  (alarmAck)
	);

	// ==================================================
	// tod pulse and counters
	// ==================================================
	todSync #(
		.SYNC_STAGES(SYNC_STAGES)
	) todIn (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.tod_i    (tod_i),
		.todEdge_o(todEdge)
	);

	timeCounter timeCnt (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.todEdge_i  (todEdge),
		.todEnable_i(todEnable),
		.rate_i     (rate),
		.loadTime_i (loadTime),
		.loadValue_i(shadowTime),
		.time_o     (liveTime),
		.dayTick_o  (dayTick)
	);

	dateCounter dateCnt (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.dayTick_i  (dayTick),
		.loadDate_i (loadDate),
		.loadValue_i(shadowDate),
		.date_o     (liveDate)
	);

	// alarm compare and interrupt
	alarmMatch alarm (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.liveTime_i (liveTime),
		.liveDate_i (liveDate),
		.alarmTime_i(alarmTime),
		.alarmDate_i(alarmDate),
		.careMask_i (alarmCare),
		.alarmAck_i (alarmAck),
		.alarmIrq_o (alarmIrq_o)
	);

endmodule

// ==== bench/rtcTb.sv ====
`timescale 1ns/1ps

module rtcTb;

	localparam int NUM_CASES = 12;
	// bus cycles to wait for ack before giving up
	localparam int ACK_LIMIT = 16;

	logic        clk;
	logic        rst;
	logic        csIo;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [3:0]  sel;
	logic [31:0] adr;
	logic [31:0] datIn;
	logic        tod;
	logic        ack;
	logic [31:0] datOut;
	logic        alarmIrq;

	// ==================================================
	// case table with one entry per index
	// ==================================================
	string       caseName [NUM_CASES];
	logic [31:0] startTime [NUM_CASES];
	logic [31:0] startDate [NUM_CASES];
	logic [1:0]  caseRate [NUM_CASES];
	logic        caseEnable [NUM_CASES];
	int          pulseCount [NUM_CASES];
	logic [31:0] alarmTimeSet [NUM_CASES];
	logic [31:0] alarmDateSet [NUM_CASES];
	logic [7:0]  careSet [NUM_CASES];
	logic [31:0] expTime [NUM_CASES];
	logic [31:0] expDate [NUM_CASES];
	logic        expIrq [NUM_CASES];

	int     caseCount = 0;
	int     errorCount = 0;
	int     passCount = 0;
	int     failCount = 0;
	int     cycleCount = 0;
	int     cycleLimit = 0;
	integer seed = 32'h5759;

	rtcTop #(
		.SYNC_STAGES(2),
		.RESET_RATE (calendarPkg::RATE_100)
	) DUT (
		.clk_i     (clk),
		.rst_i     (rst),
		.csIo_i    (csIo),
		.cyc_i     (cyc),
		.stb_i     (stb),
		.we_i      (we),
		.sel_i     (sel),
		.adr_i     (adr),
		.dat_i     (datIn),
		.tod_i     (tod),
		.ack_o     (ack),
		.dat_o     (datOut),
		.alarmIrq_o(alarmIrq)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// watchdog with the limit set once the table is built
	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Regression failed");
			$finish;
		end
	end

	// decimal 0..99 to two BCD digits
	function automatic logic [7:0] toBcd2(input int value);
		logic [7:0] result;
		result[7:4] = 4'(value / 10);
		result[3:0] = 4'(value % 10);
		return result;
	endfunction

	task automatic checkValue(input string label, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[FAIL] %s: expected %h, actual %h", label, expected, actual);
			errorCount++;
		end
	endtask

	task automatic busIdle();
		csIo  = 1'b0;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		sel   = 4'd0;
		adr   = 32'd0;
		datIn = 32'd0;
	endtask

	// ==================================================
	// bus transfers driven on the falling edge
	// ==================================================
	task automatic busWrite(input logic [2:0] idx, input logic [31:0] data,
		input logic [3:0] lanes);
		int waitCycles;
		waitCycles = 0;
		@(negedge clk);
		csIo  = 1'b1;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = 1'b1;
		sel   = lanes;
		adr   = {27'd0, idx, 2'b00};
		datIn = data;
		@(negedge clk);
		while (!ack && waitCycles < ACK_LIMIT) begin
			@(negedge clk);
			waitCycles++;
		end
		assert (ack) else begin
			$display("no acknowledge from the DUT on a write to register %0d", idx);
			errorCount++;
		end
		busIdle();
	endtask

	task automatic busRead(input logic [2:0] idx, output logic [31:0] data);
		int waitCycles;
		waitCycles = 0;
		@(negedge clk);
		csIo = 1'b1;
		cyc  = 1'b1;
		stb  = 1'b1;
		we   = 1'b0;
		sel  = 4'hF;
		adr  = {27'd0, idx, 2'b00};
		@(negedge clk);
		while (!ack && waitCycles < ACK_LIMIT) begin
			@(negedge clk);
			waitCycles++;
		end
		data = datOut;
		assert (ack) else begin
			$display("no acknowledge from the DUT on a read of register %0d", idx);
			errorCount++;
		end
		busIdle();
	endtask

	task automatic todPulse();
		@(negedge clk);
		tod = 1'b1;
		repeat (4) @(negedge clk);
		tod = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	// snapshot the live counters and read both shadows
	task automatic capture(output logic [31:0] timeValue, output logic [31:0] dateValue);
		busWrite(3'd5, 32'h0000_0001, 4'b0001);
		busRead(3'd0, timeValue);
		busRead(3'd1, dateValue);
	endtask

	task automatic loadClock(input logic [31:0] timeValue, input logic [31:0] dateValue);
		busWrite(3'd0, timeValue, 4'b1111);
		busWrite(3'd1, dateValue, 4'b1111);
		busWrite(3'd5, 32'h0000_0002, 4'b0001);
	endtask

	task automatic loadAlarm(input logic [31:0] timeValue, input logic [31:0] dateValue);
		busWrite(3'd2, timeValue, 4'b1111);
		busWrite(3'd3, dateValue, 4'b1111);
		busWrite(3'd5, 32'h0000_0100, 4'b0010);
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("test %s finished: ok", name);
		end else begin
			failCount++;
			$display("test %s finished: %0d mismatches", name, errorCount - errorsBefore);
		end
	endtask

	task automatic addCase(input string name, input logic [31:0] t0, input logic [31:0] d0,
		input logic [1:0] r, input logic en, input int n, input logic [31:0] at,
		input logic [31:0] ad, input logic [7:0] m, input logic [31:0] et,
		input logic [31:0] ed, input logic ei);
		caseName[caseCount]     = name;
		startTime[caseCount]    = t0;
		startDate[caseCount]    = d0;
		caseRate[caseCount]     = r;
		caseEnable[caseCount]   = en;
		pulseCount[caseCount]   = n;
		alarmTimeSet[caseCount] = at;
		alarmDateSet[caseCount] = ad;
		careSet[caseCount]      = m;
		expTime[caseCount]      = et;
		expDate[caseCount]      = ed;
		expIrq[caseCount]       = ei;
		caseCount++;
	endtask

	// ==================================================
	// table of calendar cases
	// ==================================================
	task automatic buildTable();
		int startSec;
		int endSec;
		int endMin;
		// alarm 0000-00-00 never matches a real date
		addCase("yearRollover", 32'h2359_5999, 32'h2023_1231, 2'd0, 1'b1, 1,
			32'h0, 32'h0, 8'hFF, 32'h0000_0000, 32'h2024_0101, 1'b0);
		addCase("year9999", 32'h2359_5999, 32'h9999_1231, 2'd0, 1'b1, 1,
			32'h0, 32'h0, 8'hFF, 32'h0000_0000, 32'h0000_0101, 1'b0);
		addCase("leap2024", 32'h2359_5999, 32'h2024_0228, 2'd0, 1'b1, 1,
			32'h0, 32'h0, 8'hFF, 32'h0000_0000, 32'h2024_0229, 1'b0);
		addCase("leap2000", 32'h2359_5999, 32'h2000_0228, 2'd0, 1'b1, 1,
			32'h0, 32'h0, 8'hFF, 32'h0000_0000, 32'h2000_0229, 1'b0);
		addCase("common2100", 32'h2359_5999, 32'h2100_0228, 2'd0, 1'b1, 1,
			32'h0, 32'h0, 8'hFF, 32'h0000_0000, 32'h2100_0301, 1'b0);
		addCase("common2023", 32'h2359_5999, 32'h2023_0228, 2'd0, 1'b1, 1,
			32'h0, 32'h0, 8'hFF, 32'h0000_0000, 32'h2023_0301, 1'b0);
		// 60 Hz tops out at 59, 50 Hz at 49
		addCase("rate60", 32'h1200_0058, 32'h2020_0315, 2'd1, 1'b1, 2,
			32'h0, 32'h0, 8'hFF, 32'h1200_0100, 32'h2020_0315, 1'b0);
		addCase("rate50", 32'h1200_0048, 32'h2020_0315, 2'd2, 1'b1, 2,
			32'h0, 32'h0, 8'hFF, 32'h1200_0100, 32'h2020_0315, 1'b0);
		addCase("todDisabled", 32'h1200_0010, 32'h2020_0315, 2'd0, 1'b0, 3,
			32'h0, 32'h0, 8'hFF, 32'h1200_0010, 32'h2020_0315, 1'b0);
		// jiffy 98 plus three ticks carries once into the seconds
		startSec = $unsigned($random(seed)) % 60;
		endSec   = (startSec + 1) % 60;
		endMin   = (startSec == 59) ? 21 : 20;
		addCase("randomSecond", {8'h10, 8'h20, toBcd2(startSec), 8'h98}, 32'h2015_0505,
			2'd0, 1'b1, 3, 32'h0, 32'h0, 8'hFF,
			{8'h10, toBcd2(endMin), toBcd2(endSec), 8'h01}, 32'h2015_0505, 1'b0);
		// date bytes masked out so only the time has to match
		addCase("alarmHit", 32'h0815_3010, 32'h2019_0704, 2'd0, 1'b1, 3,
			32'h0815_3012, 32'h0, 8'h0F, 32'h0815_3013, 32'h2019_0704, 1'b1);
		addCase("alarmMiss", 32'h0815_3010, 32'h2019_0704, 2'd0, 1'b1, 3,
			32'h0815_3100, 32'h0, 8'h0F, 32'h0815_3013, 32'h2019_0704, 1'b0);
	endtask

	task automatic runCase(input int i);
		int          errorsBefore;
		logic [31:0] gotTime;
		logic [31:0] gotDate;
		logic [31:0] gotWord;
		errorsBefore = errorCount;
		busWrite(3'd4, {21'd0, caseRate[i], caseEnable[i], careSet[i]}, 4'b0011);
		loadClock(startTime[i], startDate[i]);
		loadAlarm(alarmTimeSet[i], alarmDateSet[i]);
		// read back the alarm shadow, which also clears a leftover interrupt
		busRead(3'd2, gotWord);
		checkValue({caseName[i], " alarm readback"}, alarmTimeSet[i], gotWord);
		repeat (pulseCount[i]) todPulse();
		capture(gotTime, gotDate);
		checkValue({caseName[i], " time"}, expTime[i], gotTime);
		checkValue({caseName[i], " date"}, expDate[i], gotDate);
		checkValue({caseName[i], " irq"}, {31'd0, expIrq[i]}, {31'd0, alarmIrq});
		if (expIrq[i]) begin
			busRead(3'd2, gotWord);
			@(negedge clk);
			checkValue({caseName[i], " irq after ack"}, 32'd0, {31'd0, alarmIrq});
		end
		reportTest(caseName[i], errorsBefore);
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		int          errorsBefore;
		int          totalPulses;
		logic [31:0] gotTime;
		logic [31:0] gotDate;
		logic [31:0] gotWord;
		rst = 1'b1;
		tod = 1'b0;
		busIdle();
		buildTable();
		totalPulses = 0;
		for (int i = 0; i < caseCount; i++) begin
			totalPulses += pulseCount[i];
		end
		cycleLimit = 200 * totalPulses + 2000;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		// reset values straight out of reset
		errorsBefore = errorCount;
		@(negedge clk);
		checkValue("resetState ack", 32'd0, {31'd0, ack});
		checkValue("resetState dat_o", 32'd0, datOut);
		capture(gotTime, gotDate);
		checkValue("resetState time", 32'h1306_0000, gotTime);
		checkValue("resetState date", 32'h2012_0610, gotDate);
		busRead(3'd4, gotWord);
		checkValue("resetState control", 32'h0000_01FF, gotWord);
		checkValue("resetState irq", 32'd0, {31'd0, alarmIrq});
		reportTest("resetState", errorsBefore);

		// partial select only touches bytes 2 and 0
		errorsBefore = errorCount;
		busWrite(3'd0, 32'h1122_3344, 4'b1111);
		busWrite(3'd0, 32'hAABB_CCDD, 4'b0101);
		busRead(3'd0, gotWord);
		checkValue("byteLanes shadow", 32'h11BB_33DD, gotWord);
		busRead(3'd5, gotWord);
		checkValue("byteLanes snapshot read", 32'd0, gotWord);
		reportTest("byteLanes", errorsBefore);

		for (int i = 0; i < caseCount; i++) begin
			runCase(i);
		end

		$display("tests: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0 && errorCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
hw/calendarPkg.sv
hw/rtcRegPkg.sv
hw/todSync.sv
hw/timeCounter.sv
hw/dateCounter.sv
hw/alarmMatch.sv
hw/rtcRegs.sv
hw/rtcTop.sv
bench/rtcTb.sv

// ==== Bender.yml ====
package:
  name: bcd_rtc

sources:
  - hw/calendarPkg.sv
  - hw/rtcRegPkg.sv
  - hw/todSync.sv
  - hw/timeCounter.sv
  - hw/dateCounter.sv
  - hw/alarmMatch.sv
  - hw/rtcRegs.sv
  - hw/rtcTop.sv
  - target: test
    files:
      - bench/rtcTb.sv
